// File: Makefile
# Verilator build and run for the pipeline trace unit testbench

VERILATOR = verilator
VFLAGS    = --binary --timing -j 0
TOP       = tb_trace_unit
FILELIST  = compile.f
BUILD_DIR = obj_dir
SIM       = $(BUILD_DIR)/V$(TOP)
LOG       = sim.log
SOURCES   = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

# the log decides pass or fail
run: $(SIM)
	./$(SIM) | tee $(LOG)
	@grep -q "TESTBENCH PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: compile.f
source/pipe_pkg.sv
source/trace_pkg.sv
source/cycle_timer.sv
source/trace_ctrl.sv
source/id_pipe.sv
source/stamp_table.sv
source/trace_unit.sv
dv/tb_trace_unit.sv

// File: dv/tb_trace_unit.sv
// trace unit testbench: table-driven stimulus checked against a behavioural pipeline model
`timescale 1ns/100ps

module tb_trace_unit;
    import pipe_pkg::*;
    import trace_pkg::*;

    // one stimulus row, applied for one clock
    typedef struct packed {
        logic       start;
        logic       stop;
        logic       stall;
        logic       flush;
        instr_t     instr;
        logic [2:0] test;
    } row_t;

    logic        clk;
    logic        rst;
    logic        start;
    logic        stop;
    logic        stall;
    logic        flush;
    instr_t      fetch_instr;
    retire_rec_t retire_rec;
    logic        retire_valid;
    logic        session_done;

    row_t        rows [$];
    bit          table_ready = 1'b0;
    retire_rec_t exp_q [$];
    int          errors = 0;
    int          test_errs = 0;
    int          test_recs = 0;
    int          total_recs = 0;
    int          tests_run = 0;

    // model state
    ctrl_state_e m_state;
    logic        m_valid [STAGE_COUNT];
    retire_rec_t m_rec [STAGE_COUNT];
    seq_id_t     m_next_seq;
    logic        m_done;
    logic        m_fetched;
    int          edge_idx;
    int          sess_base;

    trace_unit #(
        .TABLE_DEPTH (8)
    ) dut (
        .clk          (clk),
        .rst          (rst),
        .start        (start),
        .stop         (stop),
        .stall        (stall),
        .flush        (flush),
        .fetch_instr  (fetch_instr),
        .retire_rec   (retire_rec),
        .retire_valid (retire_valid),
        .session_done (session_done)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    //////////////////////////////////////////////////////////////////////
    // helpers
    //////////////////////////////////////////////////////////////////////

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp_val);
        if (got !== exp_val) begin
            $display("CHECK FAILED %s: got %h expected %h", name, got, exp_val);
            errors++;
            test_errs++;
        end
    endtask

    task automatic add_rows(input int n, input logic st, input logic sp, input logic sl,
                            input logic fl, input int t);
        row_t r;
        for (int k = 0; k < n; k++) begin
            r = '{st, sp, sl, fl, $urandom(), 3'(t)};
            rows.push_back(r);
        end
    endtask

    function automatic string test_name(input int t);
        case (t)
            1: return "straight run";
            2: return "stall";
            3: return "flush";
            4: return "stop and drain";
            default: return "seq wrap";
        endcase
    endfunction

    // one call per edge, inputs are the ones the DUT samples at this edge
    task automatic model_step(input row_t in);
        retire_rec_t n_rec [STAGE_COUNT];
        logic        n_valid [STAGE_COUNT];
        logic        empty;
        logic        front_move;
        cycle_t      now;
        empty = 1'b1;
        for (int s = 0; s < STAGE_COUNT; s++) begin
            if (m_valid[s]) begin
                empty = 1'b0;
            end
        end
        front_move = !in.stall && !in.flush;
        now = cycle_t'(edge_idx - sess_base);
        m_fetched = 1'b0;
        // leaving write-back now, pulse shows next cycle
        if (m_valid[STAGE_WB]) begin
            exp_q.push_back(m_rec[STAGE_WB]);
        end
        n_valid[STAGE_WB] = m_valid[STAGE_MEM];
        n_rec[STAGE_WB] = m_rec[STAGE_MEM];
        n_rec[STAGE_WB].wb_stamp = now;
        n_valid[STAGE_MEM] = m_valid[STAGE_EXEC];
        n_rec[STAGE_MEM] = m_rec[STAGE_EXEC];
        n_rec[STAGE_MEM].mem_stamp = now;
        // a held front end leaves a bubble in execute
        n_valid[STAGE_EXEC] = front_move && m_valid[STAGE_DECODE];
        n_rec[STAGE_EXEC] = m_rec[STAGE_DECODE];
        n_rec[STAGE_EXEC].exec_stamp = now;
        n_rec[STAGE_DECODE] = m_rec[STAGE_DECODE];
        n_valid[STAGE_DECODE] = m_valid[STAGE_DECODE];
        n_rec[STAGE_FETCH] = m_rec[STAGE_FETCH];
        n_valid[STAGE_FETCH] = m_valid[STAGE_FETCH];
        if (in.flush) begin
            n_valid[STAGE_FETCH] = 1'b0;
            n_valid[STAGE_DECODE] = 1'b0;
        end else if (!in.stall) begin
            n_valid[STAGE_DECODE] = m_valid[STAGE_FETCH];
            n_rec[STAGE_DECODE] = m_rec[STAGE_FETCH];
            n_rec[STAGE_DECODE].decode_stamp = now;
            n_valid[STAGE_FETCH] = (m_state == CTRL_RUN);
            if (n_valid[STAGE_FETCH]) begin
                n_rec[STAGE_FETCH] = '0;
                n_rec[STAGE_FETCH].seq = m_next_seq;
                n_rec[STAGE_FETCH].fetch_stamp = now;
                m_next_seq = m_next_seq + 8'd1;
                m_fetched = 1'b1;
            end
        end
        m_valid = n_valid;
        m_rec = n_rec;
        // session FSM
        m_done = (m_state == CTRL_DRAIN) && empty;
        case (m_state)
            CTRL_IDLE: begin
                if (in.start) begin
                    m_state = CTRL_RUN;
                    sess_base = edge_idx + 1;
                end
            end
            CTRL_RUN: begin
                if (in.stop) begin
                    m_state = CTRL_DRAIN;
                end
            end
            default: begin
                if (empty) begin
                    m_state = CTRL_IDLE;
                end
            end
        endcase
    endtask

    // outputs here are the values of the cycle before this edge
    task automatic check_outputs();
        retire_rec_t want;
        if (retire_valid) begin
            if (exp_q.size() == 0) begin
                $display("extra retire record with seq %h", retire_rec.seq);
                errors++;
                test_errs++;
            end else begin
                want = exp_q.pop_front();
                check_value("retire_rec.seq", 32'(retire_rec.seq), 32'(want.seq));
                check_value("retire_rec.instr", retire_rec.instr, want.instr);
                check_value("retire_rec.fetch_stamp", 32'(retire_rec.fetch_stamp),
                            32'(want.fetch_stamp));
                check_value("retire_rec.decode_stamp", 32'(retire_rec.decode_stamp),
                            32'(want.decode_stamp));
                check_value("retire_rec.exec_stamp", 32'(retire_rec.exec_stamp),
                            32'(want.exec_stamp));
                check_value("retire_rec.mem_stamp", 32'(retire_rec.mem_stamp),
                            32'(want.mem_stamp));
                check_value("retire_rec.wb_stamp", 32'(retire_rec.wb_stamp),
                            32'(want.wb_stamp));
                test_recs++;
            end
        end else if (exp_q.size() != 0) begin
            want = exp_q.pop_front();
            $display("retire record for seq %h did not appear on time", want.seq);
            errors++;
            test_errs++;
        end
        check_value("session_done", 32'(session_done), 32'(m_done));
    endtask

    task automatic finish_test(input int t);
        retire_rec_t lost;
        while (exp_q.size() != 0) begin
            lost = exp_q.pop_front();
            $display("record for seq %h never retired", lost.seq);
            errors++;
            test_errs++;
        end
        $display("test %0d %s: %0d records, %0d errors", t, test_name(t), test_recs, test_errs);
        tests_run++;
        total_recs += test_recs;
        test_recs = 0;
        test_errs = 0;
    endtask

    //////////////////////////////////////////////////////////////////////
    // stimulus table and main loop
    //////////////////////////////////////////////////////////////////////

    initial begin
        row_t cur;
        void'($urandom(60));
        rst <= 1'b1;
        start <= 1'b0;
        stop <= 1'b0;
        stall <= 1'b0;
        flush <= 1'b0;
        fetch_instr <= '0;
        m_state = CTRL_IDLE;
        m_next_seq = '0;
        m_done = 1'b0;
        m_fetched = 1'b0;
        edge_idx = 0;
        sess_base = 0;
        cur = '0;
        for (int s = 0; s < STAGE_COUNT; s++) begin
            m_valid[s] = 1'b0;
            m_rec[s] = '0;
        end

        // stop at row 10 of a session gives ten fetches
        add_rows(1, 1, 0, 0, 0, 1);
        add_rows(9, 0, 0, 0, 0, 1);
        add_rows(1, 0, 1, 0, 0, 1);
        add_rows(14, 0, 0, 0, 0, 1);
        add_rows(1, 1, 0, 0, 0, 2);
        add_rows(4, 0, 0, 0, 0, 2);
        add_rows(3, 0, 0, 1, 0, 2);
        add_rows(4, 0, 0, 0, 0, 2);
        add_rows(1, 0, 1, 0, 0, 2);
        add_rows(16, 0, 0, 0, 0, 2);
        // second flush also has stall high
        add_rows(1, 1, 0, 0, 0, 3);
        add_rows(4, 0, 0, 0, 0, 3);
        add_rows(1, 0, 0, 0, 1, 3);
        add_rows(3, 0, 0, 0, 0, 3);
        add_rows(1, 0, 0, 1, 1, 3);
        add_rows(3, 0, 0, 0, 0, 3);
        add_rows(1, 0, 1, 0, 0, 3);
        add_rows(16, 0, 0, 0, 0, 3);
        // start inside a session is ignored, restart after the drain
        for (int k = 0; k < 2; k++) begin
            add_rows(1, 1, 0, 0, 0, 4);
            add_rows(3, 0, 0, 0, 0, 4);
            add_rows(1, 1, 0, 0, 0, 4);
            add_rows(2, 0, 0, 0, 0, 4);
            add_rows(1, 0, 1, 0, 0, 4);
            add_rows(16, 0, 0, 0, 0, 4);
        end
        add_rows(1, 1, 0, 0, 0, 5);
        for (int k = 0; k < 300; k++) begin
            add_rows(1, 0, 0, ($urandom_range(15) == 0), 0, 5);
        end
        add_rows(1, 0, 1, 0, 0, 5);
        add_rows(16, 0, 0, 0, 0, 5);
        table_ready = 1'b1;

        repeat (8) @(posedge clk);
        rst <= 1'b0;

        for (int i = 0; i < rows.size(); i++) begin
            @(posedge clk);
            edge_idx++;
            check_outputs();
            if (i > 0 && rows[i].test != rows[i-1].test) begin
                finish_test(int'(rows[i-1].test));
            end
            model_step(cur);
            // word on the bus in the fetch entry cycle
            if (m_fetched) begin
                m_rec[STAGE_FETCH].instr = rows[i].instr;
            end
            start <= rows[i].start;
            stop <= rows[i].stop;
            stall <= rows[i].stall;
            flush <= rows[i].flush;
            fetch_instr <= rows[i].instr;
            cur = rows[i];
        end
        @(posedge clk);
        edge_idx++;
        check_outputs();
        finish_test(int'(cur.test));

        $display("tests %0d, records %0d, errors %0d", tests_run, total_recs, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

    // watchdog, sized from the table length
    initial begin
        wait (table_ready);
        #((rows.size() + 20) * 8);
        $display("timeout: the run did not finish within the expected time");
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

// File: source/cycle_timer.sv
// session cycle timer: cleared at session start, provides the stage entry stamps
`timescale 1ns/100ps

module cycle_timer #(
    parameter int WIDTH = $bits(trace_pkg::cycle_t)
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              clear,
    input  logic              active,
    output trace_pkg::cycle_t cycle_now
);

    // running count, wraps at full scale
    logic [WIDTH-1:0] count;
    // active delayed by one edge
    logic             active_q;

    // the fetch slot fills one edge after the controller enters run,
    // so counting runs one cycle behind active and the first fetch
    // sees stamp 0
    always_ff @(posedge clk) begin
        if (rst) begin
            count    <= '0;
            active_q <= 1'b0;
        end else begin
            active_q <= active;
            if (clear) begin
                count <= '0;
            end else if (active_q) begin
                count <= count + 1'b1;
            end
        end
    end

    assign cycle_now = count;

endmodule

// File: source/id_pipe.sv
// sequence id pipeline: five tagged slots with stall hold, bubble insert and flush kill
`timescale 1ns/100ps

module id_pipe (
    input  logic                                              clk,
    input  logic                                              rst,
    input  logic                                              fetch_en,
    input  logic                                              stall,
    input  logic                                              flush,
    output trace_pkg::stage_tag_t [pipe_pkg::STAGE_COUNT-1:0] stage_tags,
    output logic [pipe_pkg::STAGE_COUNT-1:0]                  stage_enter,
    output logic                                              pipe_empty
);
    import pipe_pkg::*;
    import trace_pkg::*;

    // id handed to the next valid fetch
    seq_id_t                      next_seq;
    stage_tag_t [STAGE_COUNT-1:0] slot;
    // front of pipe may advance this edge
    logic                         front_move;
    logic                         fetch_load;

    assign front_move = !stall && !flush;
    assign fetch_load = fetch_en && front_move;

    //////////////////////////////////////////////////////////////////////
    // slot update
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            next_seq    <= '0;
            slot        <= '0;
            stage_enter <= '0;
        end else begin
            // ids are consumed only by a real fetch
            if (fetch_load) begin
                next_seq <= next_seq + 1'b1;
            end

            // front two slots: flush kills, stall holds
            if (flush) begin
                slot[STAGE_FETCH]  <= '0;
                slot[STAGE_DECODE] <= '0;
            end else if (!stall) begin
                slot[STAGE_FETCH].valid <= fetch_en;
                slot[STAGE_FETCH].seq   <= next_seq;
                slot[STAGE_DECODE]      <= slot[STAGE_FETCH];
            end

            // execute takes a bubble whenever the front does not move
            slot[STAGE_EXEC] <= front_move ? slot[STAGE_DECODE] : '0;
            // back end always shifts
            slot[STAGE_MEM]  <= slot[STAGE_EXEC];
            slot[STAGE_WB]   <= slot[STAGE_MEM];

            // new live occupant per slot, held slots do not re-enter
            stage_enter[STAGE_FETCH]  <= fetch_load;
            stage_enter[STAGE_DECODE] <= front_move && slot[STAGE_FETCH].valid;
            stage_enter[STAGE_EXEC]   <= front_move && slot[STAGE_DECODE].valid;
            stage_enter[STAGE_MEM]    <= slot[STAGE_EXEC].valid;
            stage_enter[STAGE_WB]     <= slot[STAGE_MEM].valid;
        end
    end

    // nothing in flight
    always_comb begin
        pipe_empty = 1'b1;
        for (int s = 0; s < STAGE_COUNT; s++) begin
            if (slot[s].valid) begin
                pipe_empty = 1'b0;
            end
        end
    end

    assign stage_tags = slot;

endmodule

// File: source/pipe_pkg.sv
// pipeline package: stage names, instruction word and trace session states
package pipe_pkg;

    //////////////////////////////////////////////////////////////////////
    // pipeline geometry
    //////////////////////////////////////////////////////////////////////

    // five-stage in-order pipe
    parameter int STAGE_COUNT = 5;

    // raw instruction word as seen at fetch
    typedef logic [31:0] instr_t;

    // stage names, also used as slot index
    typedef enum logic [2:0] {
        STAGE_FETCH  = 3'd0,
        STAGE_DECODE = 3'd1,
        STAGE_EXEC   = 3'd2,
        STAGE_MEM    = 3'd3,
        STAGE_WB     = 3'd4
    } stage_e;

    //////////////////////////////////////////////////////////////////////
    // trace session control
    //////////////////////////////////////////////////////////////////////

    // drain lets in-flight instructions retire after stop
    typedef enum logic [1:0] {
        CTRL_IDLE  = 2'd0,
        CTRL_RUN   = 2'd1,
        CTRL_DRAIN = 2'd2
    } ctrl_state_e;

endpackage

// File: source/stamp_table.sv
// stamp table: per-instruction record of entry stamps, read out at write-back
`timescale 1ns/100ps

module stamp_table #(
    parameter int TABLE_DEPTH = 8
) (
    input  logic                                              clk,
    input  logic                                              rst,
    input  trace_pkg::stage_tag_t [pipe_pkg::STAGE_COUNT-1:0] stage_tags,
    input  logic [pipe_pkg::STAGE_COUNT-1:0]                  stage_enter,
    input  pipe_pkg::instr_t                                  fetch_instr,
    input  trace_pkg::cycle_t                                 cycle_now,
    output trace_pkg::retire_rec_t                            retire_rec,
    output logic                                              retire_valid
);
    import pipe_pkg::*;
    import trace_pkg::*;

    // table index, low bits of the sequence id
    localparam int IDX_W = $clog2(TABLE_DEPTH);
    typedef logic [IDX_W-1:0] idx_t;

    retire_rec_t              rec_mem [TABLE_DEPTH];
    idx_t [STAGE_COUNT-1:0]   idx;
    logic [STAGE_COUNT-1:0]   wr;
    retire_rec_t              rec_next;

    // one write per stage, at most five ids live so entries never collide
    always_comb begin
        for (int s = 0; s < STAGE_COUNT; s++) begin
            idx[s] = stage_tags[s].seq[IDX_W-1:0];
            wr[s]  = stage_enter[s] && stage_tags[s].valid;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // stamp writes
    //////////////////////////////////////////////////////////////////////

    // fetch_instr is sampled in the fetch entry cycle
    always_ff @(posedge clk) begin
        if (wr[STAGE_FETCH]) begin
            rec_mem[idx[STAGE_FETCH]].seq         <= stage_tags[STAGE_FETCH].seq;
            rec_mem[idx[STAGE_FETCH]].instr       <= fetch_instr;
            rec_mem[idx[STAGE_FETCH]].fetch_stamp <= cycle_now;
        end
        if (wr[STAGE_DECODE]) begin
            rec_mem[idx[STAGE_DECODE]].decode_stamp <= cycle_now;
        end
        if (wr[STAGE_EXEC]) begin
            rec_mem[idx[STAGE_EXEC]].exec_stamp <= cycle_now;
        end
        if (wr[STAGE_MEM]) begin
            rec_mem[idx[STAGE_MEM]].mem_stamp <= cycle_now;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // retire readout
    //////////////////////////////////////////////////////////////////////

    // wb occupant stays one cycle only, its stamp is the current cycle
    always_comb begin
        rec_next          = rec_mem[idx[STAGE_WB]];
        rec_next.wb_stamp = cycle_now;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            retire_valid <= 1'b0;
        end else begin
            retire_valid <= stage_tags[STAGE_WB].valid;
        end
        if (stage_tags[STAGE_WB].valid) begin
            retire_rec <= rec_next;
        end
    end

endmodule

// File: source/trace_ctrl.sv
// trace session controller: idle, run and drain with a one-cycle done pulse
`timescale 1ns/100ps

module trace_ctrl (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  start,
    input  logic                  stop,
    input  logic                  pipe_empty,
    output pipe_pkg::ctrl_state_e state,
    output logic                  fetch_en,
    output logic                  session_done
);
    import pipe_pkg::*;

    ctrl_state_e state_next;

    //////////////////////////////////////////////////////////////////////
    // next state
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        state_next = state;
        case (state)
            CTRL_IDLE: begin
                // start only opens a session from idle
                if (start) begin
                    state_next = CTRL_RUN;
                end
            end
            CTRL_RUN: begin
                if (stop) begin
                    state_next = CTRL_DRAIN;
                end
            end
            CTRL_DRAIN: begin
                // wait for the last in-flight instruction to leave wb
                if (pipe_empty) begin
                    state_next = CTRL_IDLE;
                end
            end
            default: begin
                state_next = CTRL_IDLE;
            end
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // state and done pulse
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            state        <= CTRL_IDLE;
            session_done <= 1'b0;
        end else begin
            state        <= state_next;
            // high for the first idle cycle after a drain
            session_done <= (state == CTRL_DRAIN) && pipe_empty;
        end
    end

    // new fetches only while running
    assign fetch_en = (state == CTRL_RUN);

endmodule

// File: source/trace_pkg.sv
// trace package: sequence ids, cycle stamps, slot tags and the retire record
package trace_pkg;

    //////////////////////////////////////////////////////////////////////
    // scalar trace types
    //////////////////////////////////////////////////////////////////////

    // sequence number given at fetch, wraps at 256
    typedef logic [7:0] seq_id_t;

    // cycle stamp, wraps with the session timer
    typedef logic [15:0] cycle_t;

    //////////////////////////////////////////////////////////////////////
    // composite trace types
    //////////////////////////////////////////////////////////////////////

    // one pipeline slot: occupant id and whether it is live
    typedef struct packed {
        logic    valid;
        seq_id_t seq;
    } stage_tag_t;

    // record sent out when an instruction leaves write-back
    // stamps are the cycle of entry into each stage
    typedef struct packed {
        seq_id_t          seq;
        pipe_pkg::instr_t instr;
        cycle_t           fetch_stamp;
        cycle_t           decode_stamp;
        cycle_t           exec_stamp;
        cycle_t           mem_stamp;
        cycle_t           wb_stamp;
    } retire_rec_t;

endpackage

// File: source/trace_unit.sv
// pipeline trace unit top: ties session control, timer, id pipe and stamp table
`timescale 1ns/100ps

module trace_unit #(
    parameter int TABLE_DEPTH = 8
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   start,
    input  logic                   stop,
    input  logic                   stall,
    input  logic                   flush,
    input  pipe_pkg::instr_t       fetch_instr,
    output trace_pkg::retire_rec_t retire_rec,
    output logic                   retire_valid,
    output logic                   session_done
);
    import pipe_pkg::*;
    import trace_pkg::*;

    ctrl_state_e                  ctrl_state;
    logic                         fetch_en;
    logic                         pipe_empty;
    logic                         timer_clear;
    logic                         timer_active;
    cycle_t                       cycle_now;
    stage_tag_t [STAGE_COUNT-1:0] stage_tags;
    logic [STAGE_COUNT-1:0]       stage_enter;

    // a start inside a session is ignored, so it must not clear the timer
    assign timer_clear  = start && (ctrl_state == CTRL_IDLE);
    // run and drain both count
    assign timer_active = (ctrl_state != CTRL_IDLE);

    trace_ctrl u_trace_ctrl (
        .clk          (clk),
        .rst          (rst),
        .start        (start),
        .stop         (stop),
        .pipe_empty   (pipe_empty),
        .state        (ctrl_state),
        .fetch_en     (fetch_en),
        .session_done (session_done)
    );

    cycle_timer #(
        .WIDTH ($bits(cycle_t))
    ) u_cycle_timer (
        .clk       (clk),
        .rst       (rst),
        .clear     (timer_clear),
        .active    (timer_active),
        .cycle_now (cycle_now)
    );

    id_pipe u_id_pipe (
        .clk         (clk),
        .rst         (rst),
        .fetch_en    (fetch_en),
        .stall       (stall),
        .flush       (flush),
        .stage_tags  (stage_tags),
        .stage_enter (stage_enter),
        .pipe_empty  (pipe_empty)
    );

    stamp_table #(
        .TABLE_DEPTH (TABLE_DEPTH)
    ) u_stamp_table (
        .clk          (clk),
        .rst          (rst),
        .stage_tags   (stage_tags),
        .stage_enter  (stage_enter),
        .fetch_instr  (fetch_instr),
        .cycle_now    (cycle_now),
        .retire_rec   (retire_rec),
        .retire_valid (retire_valid)
    );

endmodule
